//--- tb.f
logic/pill_box_pkg.sv
logic/key_decoder.sv
logic/menu_ctl.sv
logic/rtc_clock.sv
logic/dose_schedule.sv
logic/alarm_beeper.sv
logic/display_fmt.sv
logic/pill_box_top.sv
tb/tb_clock_gen.sv
tb/pill_box_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = pill_box_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/pill_box_tb.sv
module pill_box_tb;

	localparam int TICKS_PER_SEC = 20;
	localparam int TONE_DIV      = 4;
	localparam int NSLOT         = pill_box_pkg::NUM_BOXES * pill_box_pkg::SLOTS_PER_BOX;
	localparam pill_box_pkg::key_code_t CODE_FIELD = 5'(pill_box_pkg::KEY_FIELD);
	localparam pill_box_pkg::key_code_t CODE_UP    = 5'(pill_box_pkg::KEY_UP);
	localparam pill_box_pkg::key_code_t CODE_DOWN  = 5'(pill_box_pkg::KEY_DOWN);
	localparam pill_box_pkg::key_code_t CODE_MODE  = 5'(pill_box_pkg::KEY_MODE);
	localparam pill_box_pkg::key_code_t CODE_SLOT  = 5'(pill_box_pkg::KEY_SLOT);
	localparam pill_box_pkg::key_code_t CODE_ACK   = 5'(pill_box_pkg::KEY_ACK);
	localparam pill_box_pkg::key_code_t CODE_NONE  = 5'd16;

	localparam int PRESS_CYC      = 8;
	localparam int SET_PRESSES    = 40;
	localparam int MENU_PRESSES   = 30;
	localparam int DIAL_PRESSES   = 76;     // 12 + 30 + 30 steps and field keys
	localparam int NAV_PRESSES    = 12;
	localparam int RUN_CYC        = 15 * TICKS_PER_SEC;
	localparam int ALARM_WAIT_CYC = 10 * TICKS_PER_SEC;
	localparam int BEEP_CYC       = 40;
	localparam int STIM_CYC = PRESS_CYC * (SET_PRESSES + DIAL_PRESSES + MENU_PRESSES +
		NAV_PRESSES + 4 * (DIAL_PRESSES + NAV_PRESSES)) + RUN_CYC + 2 * ALARM_WAIT_CYC +
		2 * BEEP_CYC;
	localparam int TIMEOUT_CYC = 4 * STIM_CYC;

	logic                     clk;
	logic                     rst_n;
	pill_box_pkg::key_code_t  keyvalue;
	logic [23:0]              time_din;
	logic [27:0]              pill_box_din;
	logic                     beep;
	logic [2:0]               alarm_box;
	pill_box_pkg::menu_mode_t mode_out;
	pill_box_pkg::slot_idx_t  index_out;

	// reference model state
	pill_box_pkg::hms_t        m_now;
	int                        m_presc;
	logic                      m_new_sec;
	pill_box_pkg::menu_mode_t  m_mode;
	pill_box_pkg::edit_field_t m_field;
	pill_box_pkg::slot_idx_t   m_slot;
	pill_box_pkg::hms_t        m_slot_time [NSLOT];
	logic [NSLOT-1:0]          m_slot_en;
	logic [NSLOT-1:0]          m_alarm;
	logic [23:0]               m_time_din;
	logic [27:0]               m_pb_din;
	pill_box_pkg::key_code_t   key_hist [3];    // codes on their way to the menu
	int                        quiet_cycles;
	int                        cycle_count = 0;

	tb_clock_gen #(.PERIOD(4)) clock_gen_i (.clk(clk));

	pill_box_top #(
		.TICKS_PER_SEC (TICKS_PER_SEC),
		.TONE_DIV      (TONE_DIV)
	) dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.keyvalue     (keyvalue),
		.time_din     (time_din),
		.pill_box_din (pill_box_din),
		.beep         (beep),
		.alarm_box    (alarm_box),
		.mode_out     (mode_out),
		.index_out    (index_out)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	//////////////////////////////////////////////////
	// compare tasks
	task automatic check_hms(input string name, input pill_box_pkg::hms_t got,
			input pill_box_pkg::hms_t exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR t=%0t %s got %0d:%0d:%0d expected %0d:%0d:%0d", $time,
				name, got.hour, got.min, got.sec, exp.hour, exp.min, exp.sec));
		end
	endtask

	task automatic check_word(input string name, input logic [27:0] got,
			input logic [27:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_mode(input string name, input pill_box_pkg::menu_mode_t got,
			input pill_box_pkg::menu_mode_t exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_slot(input string name, input pill_box_pkg::slot_idx_t got,
			input pill_box_pkg::slot_idx_t exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_alarm(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_beep(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	function automatic pill_box_pkg::hms_val_t wrap_step(pill_box_pkg::hms_val_t v,
			int modulus, logic up);
		int r;
		r = up ? int'(v) + 1 : int'(v) + modulus - 1;
		return pill_box_pkg::hms_val_t'(r % modulus);
	endfunction

	function automatic pill_box_pkg::hms_t step_field(pill_box_pkg::hms_t t,
			pill_box_pkg::edit_field_t f, logic up);
		case (f)
			pill_box_pkg::FIELD_HOUR: t.hour = wrap_step(t.hour, 24, up);
			pill_box_pkg::FIELD_MIN:  t.min = wrap_step(t.min, 60, up);
			pill_box_pkg::FIELD_SEC:  t.sec = wrap_step(t.sec, 60, up);
			default: ;
		endcase
		return t;
	endfunction

	function automatic pill_box_pkg::hms_t seconds_before(pill_box_pkg::hms_t t, int d);
		int                 total;
		pill_box_pkg::hms_t r;
		total = (int'(t.hour) * 3600 + int'(t.min) * 60 + int'(t.sec) - d + 86400) % 86400;
		r.hour = pill_box_pkg::hms_val_t'(total / 3600);
		r.min  = pill_box_pkg::hms_val_t'((total / 60) % 60);
		r.sec  = pill_box_pkg::hms_val_t'(total % 60);
		return r;
	endfunction

	function automatic logic [23:0] hms_to_bcd(pill_box_pkg::hms_t t);
		return {4'(t.hour / 8'd10), 4'(t.hour % 8'd10), 4'(t.min / 8'd10),
			4'(t.min % 8'd10), 4'(t.sec / 8'd10), 4'(t.sec % 8'd10)};
	endfunction

	function automatic int flat_index();
		if (m_mode == pill_box_pkg::MODE_TIME) begin
			return 0;
		end
		return (int'(m_mode) - 1) * 3 + int'(m_slot);
	endfunction

	function automatic logic [2:0] boxes_of(logic [NSLOT-1:0] a);
		logic [2:0] r;
		for (int b = 0; b < 3; b++) begin
			r[b] = |a[b*3 +: 3];
		end
		return r;
	endfunction

	task automatic init_model();
		m_now     = '0;
		m_presc   = 0;
		m_new_sec = 1'b0;
		m_mode    = pill_box_pkg::MODE_TIME;
		m_field   = pill_box_pkg::FIELD_NONE;
		m_slot    = '0;
		for (int i = 0; i < NSLOT; i++) begin
			m_slot_time[i] = '0;
			key_hist[i % 3] = CODE_NONE;
		end
		m_slot_en    = '0;
		m_alarm      = '0;
		m_time_din   = '0;
		m_pb_din     = '0;
		quiet_cycles = 0;
	endtask

	// one rising edge with all updates taken from the state before it
	task automatic model_step();
		pill_box_pkg::key_code_t k;
		logic                    editing;
		logic                    hold;
		logic                    tick;
		logic                    up_dn;
		int                      idx;
		int                      last;
		k = key_hist[2];
		key_hist[2] = key_hist[1];
		key_hist[1] = key_hist[0];
		key_hist[0] = keyvalue;
		editing = (m_field != pill_box_pkg::FIELD_NONE);
		hold    = editing && (m_mode == pill_box_pkg::MODE_TIME);
		tick    = !hold && (m_presc == TICKS_PER_SEC - 1);
		up_dn   = editing && (k == CODE_UP || k == CODE_DOWN);
		idx     = flat_index();
		m_time_din = hms_to_bcd(m_now);
		m_pb_din = (m_mode == pill_box_pkg::MODE_TIME) ? 28'h0FFFFFF :
			{hms_to_bcd(m_slot_time[idx]), 3'b000, m_slot_en[idx]};
		if (k == CODE_ACK) begin
			m_alarm = '0;
		end else if (m_new_sec) begin
			for (int i = 0; i < NSLOT; i++) begin
				if (m_slot_en[i] && m_slot_time[i] == m_now &&
						!(editing && m_mode != pill_box_pkg::MODE_TIME && idx == i)) begin
					m_alarm[i] = 1'b1;
				end
			end
		end
		m_new_sec = tick;
		m_presc   = (hold || tick) ? 0 : m_presc + 1;
		if (up_dn && m_mode != pill_box_pkg::MODE_TIME) begin
			if (m_field == pill_box_pkg::FIELD_ENABLE) begin
				m_slot_en[idx] = !m_slot_en[idx];
			end else begin
				m_slot_time[idx] = step_field(m_slot_time[idx], m_field, k == CODE_UP);
			end
		end
		if (up_dn && m_mode == pill_box_pkg::MODE_TIME) begin
			m_now = step_field(m_now, m_field, k == CODE_UP);
		end else if (tick) begin
			m_now.sec = wrap_step(m_now.sec, 60, 1'b1);
			if (m_now.sec == 0) begin
				m_now.min = wrap_step(m_now.min, 60, 1'b1);
				if (m_now.min == 0) begin
					m_now.hour = wrap_step(m_now.hour, 24, 1'b1);
				end
			end
		end
		if (k == CODE_FIELD) begin
			last    = (m_mode == pill_box_pkg::MODE_TIME) ? 3 : 4;     // SEC or ENABLE
			m_field = pill_box_pkg::edit_field_t'(3'((int'(m_field) >= last) ? 0 :
				int'(m_field) + 1));
		end else if (!editing && k == CODE_MODE) begin
			m_mode = pill_box_pkg::menu_mode_t'(2'((int'(m_mode) + 1) % 4));
			m_slot = '0;
		end else if (!editing && k == CODE_SLOT && m_mode != pill_box_pkg::MODE_TIME) begin
			m_slot = pill_box_pkg::slot_idx_t'((int'(m_slot) + 1) % 3);
		end
	endtask

	task automatic compare_all();
		check_word("time_din", {4'h0, time_din}, {4'h0, m_time_din});
		check_word("pill_box_din", pill_box_din, m_pb_din);
		check_hms("now", dut_i.now, m_now);
		check_mode("mode_out", mode_out, m_mode);
		check_slot("index_out", index_out, m_slot);
		check_alarm("alarm_box", alarm_box, boxes_of(m_alarm));
		if (m_alarm == '0) begin
			quiet_cycles = 0;
			check_beep("beep", beep, 1'b1);
		end else begin
			quiet_cycles = (beep === 1'b0) ? 0 : quiet_cycles + 1;
			if (quiet_cycles >= 8) begin
				fail_run("beep stayed silent for 8 cycles while an alarm was pending");
			end
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers
	task automatic run_cycle(input pill_box_pkg::key_code_t code);
		@(posedge clk);
		model_step();
		#1;
		compare_all();
		keyvalue = code;
	endtask

	task automatic press(input pill_box_pkg::key_code_t code);
		run_cycle(code);
		repeat (7) run_cycle(CODE_NONE);
	endtask

	task automatic goto_field(input pill_box_pkg::edit_field_t f);
		while (m_field != f) begin
			press(CODE_FIELD);
		end
	endtask

	task automatic goto_mode(input pill_box_pkg::menu_mode_t md);
		goto_field(pill_box_pkg::FIELD_NONE);
		while (m_mode != md) begin
			press(CODE_MODE);
		end
	endtask

	task automatic select_slot(input int box, input int slot_no);
		goto_mode(pill_box_pkg::menu_mode_t'(2'(box + 1)));
		while (int'(m_slot) != slot_no) begin
			press(CODE_SLOT);
		end
	endtask

	// shortest way round to the target value
	task automatic dial_to(input int target, input int modulus);
		pill_box_pkg::hms_t t;
		int                 cur;
		int                 diff;
		t = (m_mode == pill_box_pkg::MODE_TIME) ? m_now : m_slot_time[flat_index()];
		cur = (m_field == pill_box_pkg::FIELD_HOUR) ? int'(t.hour) :
			(m_field == pill_box_pkg::FIELD_MIN) ? int'(t.min) : int'(t.sec);
		diff = (target - cur + modulus) % modulus;
		if (diff <= modulus / 2) begin
			repeat (diff) press(CODE_UP);
		end else begin
			repeat (modulus - diff) press(CODE_DOWN);
		end
	endtask

	task automatic set_hms(input pill_box_pkg::hms_t t);
		goto_field(pill_box_pkg::FIELD_HOUR);
		dial_to(int'(t.hour), 24);
		goto_field(pill_box_pkg::FIELD_MIN);
		dial_to(int'(t.min), 60);
		goto_field(pill_box_pkg::FIELD_SEC);
		dial_to(int'(t.sec), 60);
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYC) begin
			fail_run($sformatf("timeout, the run went past %0d cycles", TIMEOUT_CYC));
		end
	end

	initial begin
		pill_box_pkg::hms_t target;
		int                 box;
		int                 slot_no;
		int                 waited;
		void'($urandom(32'h4706_a369));
		keyvalue = CODE_NONE;
		rst_n    = 1'b0;
		init_model();
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_word("time_din", {4'h0, time_din}, 28'h0);
		check_word("pill_box_din", pill_box_din, 28'h0);
		check_alarm("alarm_box", alarm_box, 3'b000);
		check_mode("mode_out", mode_out, pill_box_pkg::MODE_TIME);
		check_slot("index_out", index_out, 2'd0);
		check_beep("beep", beep, 1'b1);

		// clock setting with random keys and a run across midnight
		repeat (SET_PRESSES) begin
			case ($urandom % 3)
				0: press(CODE_FIELD);
				1: press(CODE_UP);
				default: press(CODE_DOWN);
			endcase
		end
		set_hms('{hour: 8'd23, min: 8'd59, sec: 8'd50});
		goto_field(pill_box_pkg::FIELD_NONE);
		repeat (RUN_CYC) run_cycle(CODE_NONE);

		// menu walk
		repeat (MENU_PRESSES) begin
			case ($urandom % 5)
				0: press(CODE_FIELD);
				1: press(CODE_UP);
				2: press(CODE_DOWN);
				3: press(CODE_MODE);
				default: press(CODE_SLOT);
			endcase
		end

		// alarm a few seconds ahead of the clock
		box         = $urandom % 3;
		slot_no     = $urandom % 3;
		target.hour = pill_box_pkg::hms_val_t'($urandom % 3);
		target.min  = pill_box_pkg::hms_val_t'($urandom % 4);
		target.sec  = pill_box_pkg::hms_val_t'(10 + $urandom % 20);
		select_slot(box, slot_no);
		set_hms(target);
		goto_field(pill_box_pkg::FIELD_ENABLE);
		if (!m_slot_en[flat_index()]) begin
			press(CODE_UP);
		end
		goto_mode(pill_box_pkg::MODE_TIME);
		set_hms(seconds_before(target, 3));
		goto_field(pill_box_pkg::FIELD_NONE);
		waited = 0;
		while (alarm_box[box] !== 1'b1 && waited < ALARM_WAIT_CYC) begin
			run_cycle(CODE_NONE);
			waited++;
		end
		if (alarm_box[box] !== 1'b1) begin
			fail_run($sformatf("alarm for box %0d was never raised", box + 1));
		end
		repeat (BEEP_CYC) run_cycle(CODE_NONE);
		press(CODE_ACK);
		check_alarm("alarm_box", alarm_box, 3'b000);
		repeat (BEEP_CYC) run_cycle(CODE_NONE);

		// same slot again held in edit while its time passes
		goto_mode(pill_box_pkg::MODE_TIME);
		set_hms(seconds_before(target, 6));
		goto_field(pill_box_pkg::FIELD_NONE);
		select_slot(box, slot_no);
		goto_field(pill_box_pkg::FIELD_HOUR);
		repeat (ALARM_WAIT_CYC) run_cycle(CODE_NONE);
		goto_field(pill_box_pkg::FIELD_NONE);

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

//--- logic/pill_box_top.sv
module pill_box_top #(
	parameter int TICKS_PER_SEC = 50_000_000,
	parameter int TONE_DIV      = 50_000
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  pill_box_pkg::key_code_t            keyvalue,
	output logic [23:0]                        time_din,
	output logic [27:0]                        pill_box_din,
	output logic                               beep,
	output logic [pill_box_pkg::NUM_BOXES-1:0] alarm_box,
	output pill_box_pkg::menu_mode_t           mode_out,
	output pill_box_pkg::slot_idx_t            index_out
);

	pill_box_pkg::key_evt_t    key_evt;
	pill_box_pkg::adj_cmd_t    time_adj;
	pill_box_pkg::adj_cmd_t    slot_adj;
	logic                      hold;
	pill_box_pkg::slot_sel_t   sel;
	pill_box_pkg::hms_t        now;
	logic                      new_second;
	pill_box_pkg::hms_t        slot_view;
	logic                      slot_on;

	//////////////////////////////////////////////////
	// keys and menu
	key_decoder key_decoder_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.keyvalue (keyvalue),
		.key_evt  (key_evt)
	);

	menu_ctl menu_ctl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_evt   (key_evt),
		.time_adj  (time_adj),
		.slot_adj  (slot_adj),
		.hold      (hold),
		.sel       (sel),
		.mode_out  (mode_out),
		.index_out (index_out)
	);

	//////////////////////////////////////////////////
	// time keeping, schedule and outputs
	rtc_clock #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) rtc_clock_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.hold       (hold),
		.time_adj   (time_adj),
		.now        (now),
		.new_second (new_second)
	);

	dose_schedule dose_schedule_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.slot_adj   (slot_adj),
		.sel        (sel),
		.key_evt    (key_evt),
		.now        (now),
		.new_second (new_second),
		.slot_view  (slot_view),
		.slot_on    (slot_on),
		.alarm_box  (alarm_box)
	);

	alarm_beeper #(
		.TONE_DIV (TONE_DIV)
	) alarm_beeper_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.alarm_box (alarm_box),
		.beep      (beep)
	);

	display_fmt display_fmt_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.now          (now),
		.sel          (sel),
		.slot_view    (slot_view),
		.slot_on      (slot_on),
		.time_din     (time_din),
		.pill_box_din (pill_box_din)
	);

endmodule

//--- logic/display_fmt.sv
module display_fmt (
	input  logic                    clk,
	input  logic                    rst_n,
	input  pill_box_pkg::hms_t      now,
	input  pill_box_pkg::slot_sel_t sel,
	input  pill_box_pkg::hms_t      slot_view,
	input  logic                    slot_on,
	output logic [23:0]             time_din,
	output logic [27:0]             pill_box_din
);

	// two digits, tens first
	function automatic logic [7:0] to_bcd(pill_box_pkg::hms_val_t v);
		pill_box_pkg::bcd_digit_t tens;
		pill_box_pkg::bcd_digit_t ones;
		tens = pill_box_pkg::bcd_digit_t'(v / 8'd10);
		ones = pill_box_pkg::bcd_digit_t'(v % 8'd10);
		return {tens, ones};
	endfunction

	function automatic logic [23:0] hms_bcd(pill_box_pkg::hms_t t);
		return {to_bcd(t.hour), to_bcd(t.min), to_bcd(t.sec)};
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_din     <= '0;
			pill_box_din <= '0;
		end else begin
			time_din <= hms_bcd(now);
			if (sel.mode == pill_box_pkg::MODE_TIME) begin
				pill_box_din <= 28'h0FFFFFF;    // slot digits blanked
			end else begin
				pill_box_din <= {hms_bcd(slot_view), 3'b000, slot_on};
			end
		end
	end

endmodule

//--- logic/alarm_beeper.sv
module alarm_beeper #(
	parameter int TONE_DIV = 50_000
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [pill_box_pkg::NUM_BOXES-1:0] alarm_box,
	output logic                               beep
);

	localparam int DIV_W = $clog2(TONE_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tone;     // square wave, free running

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tone    <= 1'b0;
		end else if (div_cnt == DIV_W'(TONE_DIV - 1)) begin
			div_cnt <= '0;
			tone    <= ~tone;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign beep = ~(tone & |alarm_box);     // buzzer is active low

endmodule

//--- logic/dose_schedule.sv
module dose_schedule (
	input  logic                    clk,
	input  logic                    rst_n,
	input  pill_box_pkg::adj_cmd_t  slot_adj,
	input  pill_box_pkg::slot_sel_t sel,
	input  pill_box_pkg::key_evt_t  key_evt,
	input  pill_box_pkg::hms_t      now,
	input  logic                    new_second,
	output pill_box_pkg::hms_t      slot_view,
	output logic                    slot_on,
	output logic [pill_box_pkg::NUM_BOXES-1:0] alarm_box
);

	localparam int NSLOT = pill_box_pkg::NUM_BOXES * pill_box_pkg::SLOTS_PER_BOX;
	localparam int IDX_W = $clog2(NSLOT);

	pill_box_pkg::hms_t slot_time [NSLOT];
	logic [NSLOT-1:0]   slot_en;
	logic [NSLOT-1:0]   alarm_q;
	logic [IDX_W-1:0]   sel_idx;
	logic               edit_hit;

	// flat slot index, box 1 slot 0 while in time mode
	always_comb begin
		sel_idx = '0;
		if (sel.mode != pill_box_pkg::MODE_TIME) begin
			sel_idx = (IDX_W'(sel.mode) - IDX_W'(1)) * IDX_W'(pill_box_pkg::SLOTS_PER_BOX) +
				IDX_W'(sel.slot);
		end
	end

	assign edit_hit  = sel.editing && (sel.mode != pill_box_pkg::MODE_TIME);
	assign slot_view = slot_time[sel_idx];
	assign slot_on   = slot_en[sel_idx];

	//////////////////////////////////////////////////
	// slot storage and editing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NSLOT; i++) begin
				slot_time[i] <= '0;
			end
			slot_en <= '0;
		end else if (slot_adj.up || slot_adj.down) begin
			case (slot_adj.field)
				pill_box_pkg::FIELD_HOUR: slot_time[sel_idx].hour <= pill_box_pkg::step_val(
					slot_view.hour, pill_box_pkg::HOUR_MAX, slot_adj.up);
				pill_box_pkg::FIELD_MIN:  slot_time[sel_idx].min <= pill_box_pkg::step_val(
					slot_view.min, pill_box_pkg::MINSEC_MAX, slot_adj.up);
				pill_box_pkg::FIELD_SEC:  slot_time[sel_idx].sec <= pill_box_pkg::step_val(
					slot_view.sec, pill_box_pkg::MINSEC_MAX, slot_adj.up);
				pill_box_pkg::FIELD_ENABLE: slot_en[sel_idx] <= !slot_on;  // up or down toggles
				default: slot_en <= slot_en;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// alarm latches
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= '0;
		end else if (key_evt[pill_box_pkg::KEY_ACK]) begin
			alarm_q <= '0;  // ack clears every box
		end else if (new_second) begin
			for (int i = 0; i < NSLOT; i++) begin
				if (slot_en[i] && slot_time[i] == now &&
						!(edit_hit && sel_idx == IDX_W'(i))) begin
					alarm_q[i] <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int b = 0; b < pill_box_pkg::NUM_BOXES; b++) begin
			alarm_box[b] = |alarm_q[b*pill_box_pkg::SLOTS_PER_BOX +: pill_box_pkg::SLOTS_PER_BOX];
		end
	end

endmodule

//--- logic/rtc_clock.sv
module rtc_clock #(
	parameter int TICKS_PER_SEC = 50_000_000
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hold,
	input  pill_box_pkg::adj_cmd_t time_adj,
	output pill_box_pkg::hms_t     now,
	output logic                   new_second
);

	localparam int CNT_W = $clog2(TICKS_PER_SEC + 1);

	logic [CNT_W-1:0] presc;
	logic             tick;

	assign tick = !hold && (presc == CNT_W'(TICKS_PER_SEC - 1));

	//////////////////////////////////////////////////
	// seconds prescaler
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc      <= '0;
			new_second <= 1'b0;
		end else begin
			new_second <= tick;
			if (hold || tick) begin
				presc <= '0;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// hh:mm:ss counter and manual setting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			now <= '0;
		end else if (time_adj.up || time_adj.down) begin
			case (time_adj.field)
				pill_box_pkg::FIELD_HOUR: now.hour <= pill_box_pkg::step_val(now.hour,
					pill_box_pkg::HOUR_MAX, time_adj.up);
				pill_box_pkg::FIELD_MIN:  now.min <= pill_box_pkg::step_val(now.min,
					pill_box_pkg::MINSEC_MAX, time_adj.up);
				pill_box_pkg::FIELD_SEC:  now.sec <= pill_box_pkg::step_val(now.sec,
					pill_box_pkg::MINSEC_MAX, time_adj.up);
				default: now <= now;
			endcase
		end else if (tick) begin
			now.sec <= pill_box_pkg::step_val(now.sec, pill_box_pkg::MINSEC_MAX, 1'b1);
			if (now.sec == pill_box_pkg::MINSEC_MAX) begin      // carry into minutes
				now.min <= pill_box_pkg::step_val(now.min, pill_box_pkg::MINSEC_MAX, 1'b1);
				if (now.min == pill_box_pkg::MINSEC_MAX) begin
					now.hour <= pill_box_pkg::step_val(now.hour, pill_box_pkg::HOUR_MAX, 1'b1);
				end
			end
		end
	end

endmodule

//--- logic/menu_ctl.sv
module menu_ctl (
	input  logic                     clk,
	input  logic                     rst_n,
	input  pill_box_pkg::key_evt_t   key_evt,
	output pill_box_pkg::adj_cmd_t   time_adj,
	output pill_box_pkg::adj_cmd_t   slot_adj,
	output logic                     hold,
	output pill_box_pkg::slot_sel_t  sel,
	output pill_box_pkg::menu_mode_t mode_out,
	output pill_box_pkg::slot_idx_t  index_out
);

	pill_box_pkg::menu_mode_t  mode;
	pill_box_pkg::menu_mode_t  mode_next;
	pill_box_pkg::edit_field_t field;
	pill_box_pkg::edit_field_t field_next;
	pill_box_pkg::slot_idx_t   slot;
	pill_box_pkg::adj_cmd_t    adj;
	logic                      editing;
	logic                      nav_ok;

	assign editing = (field != pill_box_pkg::FIELD_NONE);
	// mode and slot keys only when nothing of higher priority is pressed
	assign nav_ok = !editing && !key_evt[pill_box_pkg::KEY_UP] && !key_evt[pill_box_pkg::KEY_DOWN];

	always_comb begin
		case (field)
			pill_box_pkg::FIELD_NONE: field_next = pill_box_pkg::FIELD_HOUR;
			pill_box_pkg::FIELD_HOUR: field_next = pill_box_pkg::FIELD_MIN;
			pill_box_pkg::FIELD_MIN:  field_next = pill_box_pkg::FIELD_SEC;
			pill_box_pkg::FIELD_SEC: begin
				field_next = (mode == pill_box_pkg::MODE_TIME) ?
					pill_box_pkg::FIELD_NONE : pill_box_pkg::FIELD_ENABLE;
			end
			default: field_next = pill_box_pkg::FIELD_NONE;
		endcase
		case (mode)
			pill_box_pkg::MODE_TIME: mode_next = pill_box_pkg::MODE_BOX1;
			pill_box_pkg::MODE_BOX1: mode_next = pill_box_pkg::MODE_BOX2;
			pill_box_pkg::MODE_BOX2: mode_next = pill_box_pkg::MODE_BOX3;
			default:                 mode_next = pill_box_pkg::MODE_TIME;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode  <= pill_box_pkg::MODE_TIME;
			field <= pill_box_pkg::FIELD_NONE;
			slot  <= '0;
		end else if (key_evt[pill_box_pkg::KEY_FIELD]) begin
			field <= field_next;
		end else if (nav_ok && key_evt[pill_box_pkg::KEY_MODE]) begin
			mode <= mode_next;
			slot <= '0;
		end else if (nav_ok && key_evt[pill_box_pkg::KEY_SLOT] &&
				mode != pill_box_pkg::MODE_TIME) begin
			slot <= (slot == pill_box_pkg::slot_idx_t'(pill_box_pkg::SLOTS_PER_BOX - 1)) ?
				'0 : slot + 2'd1;
		end
	end

	// up/down steps, field key wins
	always_comb begin
		adj       = '0;
		adj.field = field;
		adj.up    = editing && key_evt[pill_box_pkg::KEY_UP] &&
			!key_evt[pill_box_pkg::KEY_FIELD];
		adj.down  = editing && key_evt[pill_box_pkg::KEY_DOWN] &&
			!key_evt[pill_box_pkg::KEY_FIELD] && !key_evt[pill_box_pkg::KEY_UP];
	end

	assign time_adj  = (mode == pill_box_pkg::MODE_TIME) ? adj : '0;
	assign slot_adj  = (mode != pill_box_pkg::MODE_TIME) ? adj : '0;
	assign hold      = editing && (mode == pill_box_pkg::MODE_TIME);
	assign sel       = '{mode: mode, slot: slot, editing: editing};
	assign mode_out  = mode;
	assign index_out = slot;

endmodule

//--- logic/key_decoder.sv
module key_decoder (
	input  logic                    clk,
	input  logic                    rst_n,
	input  pill_box_pkg::key_code_t keyvalue,
	output pill_box_pkg::key_evt_t  key_evt
);

	pill_box_pkg::key_evt_t key_oh;     // one-hot of the sampled code
	pill_box_pkg::key_evt_t key_d1;
	pill_box_pkg::key_evt_t key_d2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_oh  <= '0;
			key_d1  <= '0;
			key_d2  <= '0;
			key_evt <= '0;
		end else begin
			if (!keyvalue[4]) begin
				key_oh <= pill_box_pkg::key_evt_t'(1) << keyvalue[3:0];
			end else begin
				key_oh <= '0;   // no key
			end
			key_d1  <= key_oh;
			key_d2  <= key_d1;
			key_evt <= key_d1 & ~key_d2;    // rising edge only
		end
	end

endmodule

//--- logic/pill_box_pkg.sv
package pill_box_pkg;

	typedef logic [7:0] hms_val_t;      // binary hour, minute or second

	typedef struct packed {
		hms_val_t hour;
		hms_val_t min;
		hms_val_t sec;
	} hms_t;

	typedef logic [3:0] bcd_digit_t;
	typedef logic [4:0] key_code_t;     // 16 and up means no key
	typedef logic [15:0] key_evt_t;     // one pulse bit per key

	localparam int KEY_FIELD = 0;
	localparam int KEY_UP    = 1;
	localparam int KEY_DOWN  = 2;
	localparam int KEY_MODE  = 3;
	localparam int KEY_SLOT  = 4;
	localparam int KEY_ACK   = 5;

	typedef enum logic [1:0] {
		MODE_TIME,
		MODE_BOX1,
		MODE_BOX2,
		MODE_BOX3
	} menu_mode_t;

	typedef enum logic [2:0] {
		FIELD_NONE,
		FIELD_HOUR,
		FIELD_MIN,
		FIELD_SEC,
		FIELD_ENABLE
	} edit_field_t;

	typedef logic [1:0] slot_idx_t;

	localparam int NUM_BOXES     = 3;
	localparam int SLOTS_PER_BOX = 3;

	typedef struct packed {
		edit_field_t field;
		logic        up;
		logic        down;
	} adj_cmd_t;

	typedef struct packed {
		menu_mode_t mode;
		slot_idx_t  slot;
		logic       editing;    // some field selected
	} slot_sel_t;

	localparam hms_val_t HOUR_MAX   = 8'd23;
	localparam hms_val_t MINSEC_MAX = 8'd59;

	// one step up or down with wrap between 0 and max_v
	function automatic hms_val_t step_val(hms_val_t v, hms_val_t max_v, logic up);
		if (up) begin
			return (v == max_v) ? 8'd0 : v + 8'd1;
		end
		return (v == 8'd0) ? max_v : v - 8'd1;
	endfunction

endpackage
